//--- hw/dram_traffic_pkg.sv
package dram_traffic_pkg;

    // line and sample format
    localparam int DRAM_ADDR_W      = 24;   // one line per address
    localparam int LINE_W           = 128;
    localparam int SAMPLE_W         = 16;
    localparam int SAMPLES_PER_LINE = 8;

    // response buffer depth in lines and the credit pool at reset
    localparam int RESP_DEPTH = 4;
    localparam int CREDIT_W   = 3;
    localparam int COUNT_W    = 16;  // completed-request counter

    // one dram line seen as a flat word or as samples
    // sample 0 sits in the low bits
    typedef union packed {
        logic [LINE_W-1:0]                        raw;
        logic [SAMPLES_PER_LINE-1:0][SAMPLE_W-1:0] samples;
    } dram_line_u;

    // write beat from the loader
    typedef struct packed {
        dram_line_u line;
        logic       last;  // final beat of the load
    } dram_wr_beat_t;

    // audio read address
    typedef struct packed {
        logic [DRAM_ADDR_W-1:0] addr;
    } dram_rd_req_t;

    // pipelined wishbone-style request
    typedef struct packed {
        logic                   stb;
        logic                   we;    // 1 = write
        logic [DRAM_ADDR_W-1:0] addr;
        dram_line_u             data;  // write data only
    } dram_mem_req_t;

    typedef enum logic [1:0] {
        RESET,
        LOAD,
        FLUSH,
        SERVE
    } dram_phase_e;

endpackage

//--- hw/dram_traffic_fsm.sv
`timescale 1ns/100ps

module dram_traffic_fsm (
    input  logic                          clk_dram_ctrl,
    input  logic                          rst_dram_ctrl,
    input  logic                          i_issue,            // memory took a request
    input  logic                          i_issue_last,       // ... and it was the last beat
    input  logic                          i_outstanding_zero,
    output dram_traffic_pkg::dram_phase_e o_phase,
    output logic                          o_load_complete
);

    dram_traffic_pkg::dram_phase_e phase_q;
    dram_traffic_pkg::dram_phase_e phase_d;

    // phases only advance until the next reset
    always_comb begin
        phase_d = phase_q;
        case (phase_q)
            dram_traffic_pkg::RESET: begin
                phase_d = dram_traffic_pkg::LOAD;  // one idle cycle after reset
            end
            dram_traffic_pkg::LOAD: begin
                if (i_issue && i_issue_last) begin
                    phase_d = dram_traffic_pkg::FLUSH;
                end
            end
            dram_traffic_pkg::FLUSH: begin
                // all writes must be acked before the first read goes out
                if (i_outstanding_zero) begin
                    phase_d = dram_traffic_pkg::SERVE;
                end
            end
            default: begin
                phase_d = phase_q;  // serve forever
            end
        endcase
    end

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            phase_q <= dram_traffic_pkg::RESET;
        end else begin
            phase_q <= phase_d;
        end
    end

    assign o_phase         = phase_q;
    assign o_load_complete = (phase_q == dram_traffic_pkg::SERVE);

endmodule

//--- hw/dram_credit_counter.sv
`timescale 1ns/100ps

module dram_credit_counter (
    input  logic                                 clk_dram_ctrl,
    input  logic                                 rst_dram_ctrl,
    input  logic                                 i_issue,
    input  logic                                 i_issue_read,
    input  logic                                 i_mem_ack,
    input  logic                                 i_line_credit,  // a buffer line was freed
    output logic                                 o_credit_avail,
    output logic                                 o_outstanding_zero,
    output logic [dram_traffic_pkg::COUNT_W-1:0] o_complete_count
);

    typedef logic [dram_traffic_pkg::CREDIT_W-1:0] credit_t;

    credit_t credits;
    credit_t outstanding;  // issued, not yet acked
    logic    take;

    assign take = i_issue && i_issue_read;

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            credits          <= credit_t'(dram_traffic_pkg::RESP_DEPTH);
            outstanding      <= '0;
            o_complete_count <= '0;
        end else begin
            case ({take, i_line_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;  // no event or take and return together
            endcase

            case ({i_issue, i_mem_ack})
                2'b10:   outstanding <= outstanding + 1'b1;
                2'b01:   outstanding <= outstanding - 1'b1;
                default: outstanding <= outstanding;
            endcase

            if (i_mem_ack) begin
                o_complete_count <= o_complete_count + 1'b1;  // wraps
            end
        end
    end

    // look ahead past a read issued this cycle since the register lags by one
    assign o_credit_avail     = take ? (credits > credit_t'(1)) : (credits != '0);
    assign o_outstanding_zero = (outstanding == '0);

endmodule

//--- hw/dram_request_mux.sv
`timescale 1ns/100ps

module dram_request_mux (
    input  logic                            clk_dram_ctrl,
    input  logic                            rst_dram_ctrl,
    input  dram_traffic_pkg::dram_phase_e   i_phase,
    input  logic                            i_credit_avail,

    // write beats, load phase only
    input  dram_traffic_pkg::dram_wr_beat_t i_wr,
    input  logic                            i_wr_valid,
    output logic                            o_wr_ready,

    // read addresses, serve phase only
    input  dram_traffic_pkg::dram_rd_req_t  i_rd,
    input  logic                            i_rd_valid,
    output logic                            o_rd_ready,

    output dram_traffic_pkg::dram_mem_req_t o_mem,
    input  logic                            i_mem_stall,

    output logic                            o_issue,
    output logic                            o_issue_read,
    output logic                            o_issue_last
);

    dram_traffic_pkg::dram_mem_req_t       req_q;
    logic                                  last_q;   // held beat closes the load
    logic [dram_traffic_pkg::DRAM_ADDR_W-1:0] wr_addr;  // next load address
    logic                                  accept;
    logic                                  reg_free;
    logic                                  wr_fire;
    logic                                  rd_fire;

    assign accept   = req_q.stb && !i_mem_stall;
    assign reg_free = !req_q.stb || accept;  // empty now or emptied this cycle

    // no more beats once the last one is sitting in the register
    assign o_wr_ready = (i_phase == dram_traffic_pkg::LOAD) && reg_free
                        && !(req_q.stb && last_q);
    assign o_rd_ready = (i_phase == dram_traffic_pkg::SERVE) && reg_free
                        && i_credit_avail;

    assign wr_fire = i_wr_valid && o_wr_ready;
    assign rd_fire = i_rd_valid && o_rd_ready;

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            req_q.stb <= 1'b0;
            last_q    <= 1'b0;
            wr_addr   <= '0;
        end else begin
            if (wr_fire) begin
                req_q.stb  <= 1'b1;
                req_q.we   <= 1'b1;
                req_q.addr <= wr_addr;
                req_q.data <= i_wr.line;
                last_q     <= i_wr.last;
                wr_addr    <= wr_addr + 1'b1;  // samples packed from line 0 up
            end else if (rd_fire) begin
                req_q.stb  <= 1'b1;
                req_q.we   <= 1'b0;
                req_q.addr <= i_rd.addr;
                last_q     <= 1'b0;
            end else if (accept) begin
                req_q.stb <= 1'b0;
            end
            // under stall nothing changes
        end
    end

    assign o_mem        = req_q;
    assign o_issue      = accept;
    assign o_issue_read = !req_q.we;
    assign o_issue_last = req_q.we && last_q;

endmodule

//--- hw/dram_sample_unpacker.sv
`timescale 1ns/100ps

module dram_sample_unpacker (
    input  logic                                  clk_dram_ctrl,
    input  logic                                  rst_dram_ctrl,
    input  dram_traffic_pkg::dram_phase_e         i_phase,
    input  logic                                  i_mem_ack,
    input  dram_traffic_pkg::dram_line_u          i_mem_rdata,
    output logic [dram_traffic_pkg::SAMPLE_W-1:0] o_sample,
    output logic                                  o_sample_valid,
    input  logic                                  i_sample_ready,
    output logic                                  o_line_credit
);

    typedef logic [$clog2(dram_traffic_pkg::RESP_DEPTH)-1:0]       idx_t;
    typedef logic [$clog2(dram_traffic_pkg::SAMPLES_PER_LINE)-1:0] sel_t;
    typedef logic [dram_traffic_pkg::CREDIT_W-1:0]                 fill_t;

    dram_traffic_pkg::dram_line_u line_buf [dram_traffic_pkg::RESP_DEPTH];

    idx_t  wr_idx;
    idx_t  rd_idx;
    fill_t fill;        // lines held
    sel_t  sample_sel;  // next sample of the head line
    logic  capture;
    logic  xfer;
    logic  line_done;

    // only read data is kept since write acks land before SERVE
    assign capture = i_mem_ack && (i_phase == dram_traffic_pkg::SERVE);

    assign o_sample_valid = (fill != '0);
    assign o_sample       = line_buf[rd_idx].samples[sample_sel];

    assign xfer      = o_sample_valid && i_sample_ready;
    assign line_done = xfer && (sample_sel == sel_t'(dram_traffic_pkg::SAMPLES_PER_LINE - 1));
    assign o_line_credit = line_done;

    // line storage
    always_ff @(posedge clk_dram_ctrl) begin
        if (capture) begin
            line_buf[wr_idx] <= i_mem_rdata;
        end
    end

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            wr_idx     <= '0;
            rd_idx     <= '0;
            fill       <= '0;
            sample_sel <= '0;
        end else begin
            if (capture) begin
                wr_idx <= wr_idx + 1'b1;
            end

            if (line_done) begin
                sample_sel <= '0;
                rd_idx     <= rd_idx + 1'b1;  // head line freed
            end else if (xfer) begin
                sample_sel <= sample_sel + 1'b1;
            end

            case ({capture, line_done})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

endmodule

//--- hw/dram_traffic_top.sv
`timescale 1ns/100ps

module dram_traffic_top (
    input  logic                                  clk_dram_ctrl,
    input  logic                                  rst_dram_ctrl,

    input  dram_traffic_pkg::dram_wr_beat_t       i_wr,
    input  logic                                  i_wr_valid,
    output logic                                  o_wr_ready,

    input  dram_traffic_pkg::dram_rd_req_t        i_rd,
    input  logic                                  i_rd_valid,
    output logic                                  o_rd_ready,

    output logic [dram_traffic_pkg::SAMPLE_W-1:0] o_sample,
    output logic                                  o_sample_valid,
    input  logic                                  i_sample_ready,

    output dram_traffic_pkg::dram_mem_req_t       o_mem,
    input  logic                                  i_mem_stall,
    input  logic                                  i_mem_ack,
    input  dram_traffic_pkg::dram_line_u          i_mem_rdata,

    output logic                                  o_load_complete,
    output logic [dram_traffic_pkg::COUNT_W-1:0]  o_complete_count
);

    dram_traffic_pkg::dram_phase_e phase;
    logic                          issue;
    logic                          issue_read;
    logic                          issue_last;
    logic                          credit_avail;
    logic                          outstanding_zero;
    logic                          line_credit;

    dram_traffic_fsm u_fsm (
        .clk_dram_ctrl      (clk_dram_ctrl),
        .rst_dram_ctrl      (rst_dram_ctrl),
        .i_issue            (issue),
        .i_issue_last       (issue_last),
        .i_outstanding_zero (outstanding_zero),
        .o_phase            (phase),
        .o_load_complete    (o_load_complete)
    );

    dram_credit_counter u_credit (
        .clk_dram_ctrl      (clk_dram_ctrl),
        .rst_dram_ctrl      (rst_dram_ctrl),
        .i_issue            (issue),
        .i_issue_read       (issue_read),
        .i_mem_ack          (i_mem_ack),
        .i_line_credit      (line_credit),
        .o_credit_avail     (credit_avail),
        .o_outstanding_zero (outstanding_zero),
        .o_complete_count   (o_complete_count)
    );

    dram_request_mux u_mux (
        .clk_dram_ctrl  (clk_dram_ctrl),
        .rst_dram_ctrl  (rst_dram_ctrl),
        .i_phase        (phase),
        .i_credit_avail (credit_avail),
        .i_wr           (i_wr),
        .i_wr_valid     (i_wr_valid),
        .o_wr_ready     (o_wr_ready),
        .i_rd           (i_rd),
        .i_rd_valid     (i_rd_valid),
        .o_rd_ready     (o_rd_ready),
        .o_mem          (o_mem),
        .i_mem_stall    (i_mem_stall),
        .o_issue        (issue),
        .o_issue_read   (issue_read),
        .o_issue_last   (issue_last)
    );

    dram_sample_unpacker u_unpack (
        .clk_dram_ctrl  (clk_dram_ctrl),
        .rst_dram_ctrl  (rst_dram_ctrl),
        .i_phase        (phase),
        .i_mem_ack      (i_mem_ack),
        .i_mem_rdata    (i_mem_rdata),
        .o_sample       (o_sample),
        .o_sample_valid (o_sample_valid),
        .i_sample_ready (i_sample_ready),
        .o_line_credit  (line_credit)
    );

endmodule

//--- verification/wb_mem_model.sv
`timescale 1ns/100ps

module wb_mem_model (
    input  logic                            clk_dram_ctrl,
    input  dram_traffic_pkg::dram_mem_req_t i_mem,
    output logic                            o_stall,
    output logic                            o_ack,
    output dram_traffic_pkg::dram_line_u    o_rdata
);

    typedef logic [dram_traffic_pkg::LINE_W-1:0] word_t;

    word_t       mem [256];  // indexed by the low address bits
    word_t       data_q [$];  // data returned with each pending ack
    int          due_q [$];   // cycle in which each ack is driven
    int          cycle = 0;
    int          last_due = 0;
    logic [31:0] rng = 32'd98;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    initial begin
        o_stall = 1'b0;
        o_ack   = 1'b0;
        o_rdata = '0;
    end

    // a request seen here with stall low is taken at the next rising edge
    always @(negedge clk_dram_ctrl) begin
        int delay;
        int due;
        if (i_mem.stb && !o_stall) begin
            rng   = lcg_next(rng);
            delay = 1 + int'(rng[17:16]);  // 1 to 4 cycles
            due   = cycle + delay;
            if (due <= last_due) begin
                due = last_due + 1;  // keep acks in order
            end
            last_due = due;
            if (i_mem.we) begin
                mem[i_mem.addr[7:0]] = i_mem.data.raw;
            end
            data_q.push_back(mem[i_mem.addr[7:0]]);
            due_q.push_back(due);
        end
    end

    always @(posedge clk_dram_ctrl) begin
        #1;
        cycle = cycle + 1;
        o_ack = 1'b0;
        rng   = lcg_next(rng);
        o_stall = (rng[19:18] == 2'b00);  // roughly one cycle in four
        if (due_q.size() != 0 && due_q[0] == cycle) begin
            o_ack       = 1'b1;
            o_rdata.raw = data_q.pop_front();
            void'(due_q.pop_front());
        end
    end

endmodule

//--- verification/dram_traffic_properties.sv
`timescale 1ns/100ps

module dram_traffic_properties (
    input logic                            clk_dram_ctrl,
    input logic                            rst_dram_ctrl,
    input dram_traffic_pkg::dram_mem_req_t o_mem,
    input logic                            i_mem_stall,
    input logic                            o_rd_ready,
    input logic                            o_load_complete
);

    // a stalled request stays on the bus untouched
    property req_held_under_stall;
        @(posedge clk_dram_ctrl) disable iff (rst_dram_ctrl)
            (o_mem.stb && i_mem_stall) |=> (o_mem.stb && $stable(o_mem));
    endproperty

    // reads wait for the whole load
    property no_reads_before_load;
        @(posedge clk_dram_ctrl) disable iff (rst_dram_ctrl)
            !o_load_complete |-> !o_rd_ready;
    endproperty

    property strobe_low_after_reset;
        @(posedge clk_dram_ctrl) rst_dram_ctrl |=> !o_mem.stb;
    endproperty

    a_req_held: assert property (req_held_under_stall)
        else $error("memory request changed while stalled");
    a_no_early_reads: assert property (no_reads_before_load)
        else $error("o_rd_ready high before o_load_complete");
    a_stb_reset: assert property (strobe_low_after_reset)
        else $error("strobe high in the cycle after reset");

endmodule

//--- verification/dram_traffic_tb.sv
`timescale 1ns/100ps

module dram_traffic_tb;

    localparam int N_BEATS        = 16;
    localparam int N_READS        = 64;
    localparam int SPL            = dram_traffic_pkg::SAMPLES_PER_LINE;
    localparam int N_SAMPLES      = N_READS * SPL;
    localparam int TIMEOUT_CYCLES = 4000;  // (16 + 64 * 8) * 4 worst case plus margin
    localparam int N_TESTS        = 6;

    typedef logic [dram_traffic_pkg::LINE_W-1:0]      word_t;
    typedef logic [dram_traffic_pkg::DRAM_ADDR_W-1:0] addr_t;
    typedef logic [dram_traffic_pkg::SAMPLE_W-1:0]    sample_t;

    logic                                 clk_dram_ctrl;
    logic                                 rst_dram_ctrl;
    dram_traffic_pkg::dram_wr_beat_t      i_wr;
    logic                                 i_wr_valid;
    logic                                 o_wr_ready;
    dram_traffic_pkg::dram_rd_req_t       i_rd;
    logic                                 i_rd_valid;
    logic                                 o_rd_ready;
    sample_t                              o_sample;
    logic                                 o_sample_valid;
    logic                                 i_sample_ready;
    dram_traffic_pkg::dram_mem_req_t      o_mem;
    logic                                 i_mem_stall;
    logic                                 i_mem_ack;
    dram_traffic_pkg::dram_line_u         i_mem_rdata;
    logic                                 o_load_complete;
    logic [dram_traffic_pkg::COUNT_W-1:0] o_complete_count;

    word_t       lines [N_BEATS];  // line loaded at each address
    addr_t       rd_addrs [N_READS];
    sample_t     expected_q [$];
    logic [31:0] rng;
    int          errors [N_TESTS] = '{default: 0};
    int          samples_seen = 0;
    int          lines_done = 0;
    int          reads_issued = 0;  // read strobes taken by memory
    int          mem_accepts = 0;
    int          in_accepts = 0;
    string       test_names [N_TESTS] = '{"load", "reads held during load", "read data",
                                          "back-pressure and credits", "stall accounting",
                                          "completed-request count"};

    dram_traffic_top dut (.*);

    wb_mem_model u_mem (
        .clk_dram_ctrl (clk_dram_ctrl),
        .i_mem         (o_mem),
        .o_stall       (i_mem_stall),
        .o_ack         (i_mem_ack),
        .o_rdata       (i_mem_rdata)
    );

    bind dram_traffic_top dram_traffic_properties u_props (
        .clk_dram_ctrl   (clk_dram_ctrl),
        .rst_dram_ctrl   (rst_dram_ctrl),
        .o_mem           (o_mem),
        .i_mem_stall     (i_mem_stall),
        .o_rd_ready      (o_rd_ready),
        .o_load_complete (o_load_complete)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // sample k of the line loaded at addr with sample 0 in the low bits
    function automatic sample_t ref_sample(input addr_t addr, input int k);
        word_t line;
        line = lines[addr[3:0]];
        return line[k*dram_traffic_pkg::SAMPLE_W +: dram_traffic_pkg::SAMPLE_W];
    endfunction

    task automatic check_value(input int test, input string name,
                               input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("[ERROR] %s: got %0h, expected %0h", name, actual, expected);
            errors[test]++;
        end
    endtask

    task automatic report(input int test);
        if (errors[test] == 0) begin
            $display("%s: pass", test_names[test]);
        end else begin
            $display("%s: fail, %0d errors", test_names[test], errors[test]);
        end
    endtask

    task automatic send_beats();
        for (int i = 0; i < N_BEATS; i++) begin
            i_wr.line.raw = lines[i];
            i_wr.last     = (i == N_BEATS - 1);
            i_wr_valid    = 1'b1;
            @(negedge clk_dram_ctrl);
            while (!o_wr_ready) @(negedge clk_dram_ctrl);
            @(posedge clk_dram_ctrl);
            #1;
        end
        i_wr_valid = 1'b0;
    endtask

    // the first request is already valid while the load runs
    task automatic send_reads();
        for (int n = 0; n < N_READS; n++) begin
            i_rd.addr  = rd_addrs[n];
            i_rd_valid = 1'b1;
            @(negedge clk_dram_ctrl);
            while (!o_rd_ready) @(negedge clk_dram_ctrl);
            @(posedge clk_dram_ctrl);
            #1;
        end
        i_rd_valid = 1'b0;
    endtask

    initial begin : clock_gen
        clk_dram_ctrl = 1'b0;
        forever #2 clk_dram_ctrl = ~clk_dram_ctrl;
    end

    initial begin : sink_drive
        forever begin
            @(posedge clk_dram_ctrl);
            #1;
            rng = lcg_next(rng);
            i_sample_ready = (rng[21:20] != 2'b00);  // ready about three cycles in four
        end
    end

    // handshakes seen just before the edge that completes them
    always @(negedge clk_dram_ctrl) begin : monitor
        if (!rst_dram_ctrl) begin
            if (i_wr_valid && o_wr_ready) begin
                in_accepts++;
            end
            if (i_rd_valid && o_rd_ready) begin
                in_accepts++;
                for (int k = 0; k < SPL; k++) begin
                    expected_q.push_back(ref_sample(i_rd.addr, k));
                end
            end
            if (o_mem.stb && !i_mem_stall) begin
                mem_accepts++;
            end
            if (!o_load_complete) begin
                check_value(1, "o_rd_ready", word_t'(o_rd_ready), '0);
            end
        end
    end

    always @(negedge clk_dram_ctrl) begin : compare
        sample_t exp_sample;
        if (!rst_dram_ctrl) begin
            if (o_mem.stb && !i_mem_stall && !o_mem.we) begin
                reads_issued++;
            end
            if (o_sample_valid && i_sample_ready) begin
                if (expected_q.size() == 0) begin
                    $display("sample %0d arrived with no read request behind it", samples_seen);
                    errors[2]++;
                end else begin
                    exp_sample = expected_q.pop_front();
                    check_value(2, "o_sample", word_t'(o_sample), word_t'(exp_sample));
                end
                samples_seen++;
                if (samples_seen % SPL == 0) begin
                    lines_done++;
                end
            end
            if (reads_issued - lines_done > dram_traffic_pkg::RESP_DEPTH) begin
                $display("more read lines in flight than the response buffer holds");
                errors[3]++;
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk_dram_ctrl);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Test FAILED");
        $finish;
    end

    initial begin : main
        word_t line;
        int    total;
        int    passed;
        rst_dram_ctrl  = 1'b1;
        i_wr           = '0;
        i_wr_valid     = 1'b0;
        i_rd           = '0;
        i_rd_valid     = 1'b0;
        i_sample_ready = 1'b0;
        rng            = 32'd98;
        for (int i = 0; i < N_BEATS; i++) begin
            line = '0;
            repeat (4) begin
                rng  = lcg_next(rng);
                line = (line << 32) | word_t'(rng);
            end
            lines[i] = line;
        end
        for (int n = 0; n < N_READS; n++) begin
            rng         = lcg_next(rng);
            rd_addrs[n] = addr_t'(rng[19:16]);  // addresses 0 to 15
        end

        repeat (16) @(posedge clk_dram_ctrl);
        #1;
        rst_dram_ctrl = 1'b0;
        fork
            send_beats();
            send_reads();
        join_none

        @(negedge clk_dram_ctrl);
        while (!o_load_complete) @(negedge clk_dram_ctrl);
        check_value(0, "o_complete_count", word_t'(o_complete_count), word_t'(N_BEATS));
        for (int i = 0; i < N_BEATS; i++) begin
            check_value(0, "stored line", u_mem.mem[i], lines[i]);
        end
        report(0);
        report(1);

        while (samples_seen < N_SAMPLES) @(negedge clk_dram_ctrl);
        repeat (8) @(negedge clk_dram_ctrl);  // room for a stray extra sample
        check_value(2, "samples received", word_t'(samples_seen), word_t'(N_SAMPLES));
        check_value(3, "o_sample_valid", word_t'(o_sample_valid), '0);
        report(2);
        report(3);

        check_value(4, "memory accepts", word_t'(mem_accepts), word_t'(in_accepts));
        report(4);
        check_value(5, "o_complete_count", word_t'(o_complete_count),
                    word_t'(N_BEATS + N_READS));
        report(5);

        total  = 0;
        passed = 0;
        for (int t = 0; t < N_TESTS; t++) begin
            total += errors[t];
            if (errors[t] == 0) begin
                passed++;
            end
        end
        $display("%0d of %0d tests passed, %0d errors", passed, N_TESTS, total);
        if (total == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- tb.f
hw/dram_traffic_pkg.sv
hw/dram_traffic_fsm.sv
hw/dram_credit_counter.sv
hw/dram_request_mux.sv
hw/dram_sample_unpacker.sv
hw/dram_traffic_top.sv
verification/wb_mem_model.sv
verification/dram_traffic_properties.sv
verification/dram_traffic_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the DRAM traffic testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module dram_traffic_tb \
    -f tb.f \
    -o dram_traffic_sim

./obj_dir/dram_traffic_sim | tee sim.log

if grep -q "^Test OK$" sim.log; then
    exit 0
else
    exit 1
fi
